// ==== Makefile ====
# Verilator build and run of the ILA testbench
# Any variable below can be overridden, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ila_tb
FILELIST  ?= ila_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass only if the pass line shows up"
	@echo "  clean  remove the build directory"

# Output goes to the terminal and is searched for the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/ila_capture.sv ====
`timescale 1ns/1ps

module ila_capture import ila_pkg::*; #(
	parameter int CHANNELS    = 2,
	parameter int PROBE_WIDTH = 16,
	parameter int DEPTH       = 64,	// Power of two
	localparam int ADDR_BITS  = $clog2(DEPTH),
	localparam int SAMPLE_W   = ila_sample_bits(CHANNELS, PROBE_WIDTH)
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic [SAMPLE_W-1:0]                  beat,
	input  logic                                 arm_pulse,
	input  logic [ADDR_BITS-1:0]                 trig_offset,	// Samples kept before trigger
	input  logic [ADDR_BITS-1:0]                 rd_addr,	// Index in time order
	output logic [CHANNELS-1:0][PROBE_WIDTH-1:0] rd_data,
	output ila_status_t                          status
);

	typedef struct packed {
		logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe;
		logic                                 trig;
	} ila_sample_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FILLING,	// Collecting pre-trigger history
		ST_WAITING,	// History full, looking for trigger
		ST_POST,	// Filling the rest after trigger
		ST_DONE
	} state_t;

	ila_sample_t          beat_s;
	state_t               state;
	logic                 capturing;
	logic [ADDR_BITS-1:0] wr_ptr;		// Circular, free running while capturing
	logic [ADDR_BITS-1:0] sample_cnt;	// Beats since arm, up to offset
	logic [ADDR_BITS-1:0] post_left;	// Beats still due after trigger
	logic [ADDR_BITS-1:0] offset_q;	// Offset latched at arm
	logic [ADDR_BITS-1:0] trig_addr;	// Where the trigger beat landed
	logic [ADDR_BITS-1:0] start_addr;

	logic [CHANNELS-1:0][PROBE_WIDTH-1:0] mem [DEPTH];

	assign beat_s    = beat;
	assign capturing = (state == ST_FILLING) || (state == ST_WAITING) || (state == ST_POST);

	//////////////////////////////////////////////////////////////////////
	// Capture FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			wr_ptr     <= '0;
			sample_cnt <= '0;
			post_left  <= '0;
			offset_q   <= '0;
			trig_addr  <= '0;
		end else begin
			if (capturing)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at DEPTH

			if (arm_pulse) begin
				offset_q   <= trig_offset;
				sample_cnt <= '0;
				state      <= (trig_offset == '0) ? ST_WAITING : ST_FILLING;
			end else begin
				case (state)
					ST_FILLING: begin
						sample_cnt <= sample_cnt + 1'b1;
						if (sample_cnt + 1'b1 == offset_q)
							state <= ST_WAITING;	// Trigger accepted from next beat
					end
					ST_WAITING: begin
						if (beat_s.trig) begin
							trig_addr <= wr_ptr;
							post_left <= ~offset_q;	// DEPTH-1-offset
							// Offset of DEPTH-1 leaves nothing after the trigger
							state     <= (offset_q == '1) ? ST_DONE : ST_POST;
						end
					end
					ST_POST: begin
						post_left <= post_left - 1'b1;
						if (post_left == ADDR_BITS'(1))
							state <= ST_DONE;
					end
					default: ;	// Idle and done hold until arm
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sample memory

	// Oldest kept sample sits offset slots before the trigger
	assign start_addr = trig_addr - offset_q;

	always_ff @(posedge clk) begin
		if (capturing)
			mem[wr_ptr] <= beat_s.probe;
		rd_data <= mem[start_addr + rd_addr];	// One clock read latency
	end

	// Status straight from the FSM state
	assign status.armed     = capturing;
	assign status.triggered = (state == ST_POST) || (state == ST_DONE);
	assign status.done      = (state == ST_DONE);
	assign status.pre_full  = (state == ST_WAITING) || status.triggered;

endmodule

// ==== hw/ila_pkg.sv ====
package ila_pkg;

	//////////////////////////////////////////////////////////////////////
	// Trigger compare modes

	typedef enum logic [2:0] {
		COMPARE_ALWAYS  = 3'd0,	// Match on every sample
		COMPARE_NEVER   = 3'd1,	// Channel never matches
		COMPARE_EQUAL   = 3'd2,
		COMPARE_LEQUAL  = 3'd3,
		COMPARE_GEQUAL  = 3'd4,
		COMPARE_LESS    = 3'd5,
		COMPARE_GREATER = 3'd6,
		COMPARE_UNEQUAL = 3'd7
	} ila_compare_t;

	//////////////////////////////////////////////////////////////////////
	// Pipeline beat layout

	// Beat is {probe, trig}: trig flag in the LSB, channel 0 probe right above it
	localparam int SAMPLE_TRIG_BITS = 1;

	// Total beat width for a given channel count and probe width
	function automatic int ila_sample_bits(input int channels, input int probe_width);
		return channels * probe_width + SAMPLE_TRIG_BITS;
	endfunction

	// Capture state as seen by the host, armed in the LSB
	typedef struct packed {
		logic pre_full;		// Pre-trigger history is complete
		logic done;		// Buffer holds a finished capture
		logic triggered;	// Trigger beat accepted
		logic armed;		// Capture running
	} ila_status_t;

	//////////////////////////////////////////////////////////////////////
	// Register map, word addresses

	localparam logic [9:0] REG_CTRL        = 10'h000;
	localparam logic [9:0] REG_OFFSET      = 10'h001;
	localparam logic [9:0] REG_MODE_BASE   = 10'h010;	// One word per channel
	localparam logic [9:0] REG_TARGET_BASE = 10'h020;	// One word per channel

	// Sample space decode
	localparam int ADR_SAMPLE_BIT = 9;	// Set for sample reads
	localparam int ADR_CHAN_LSB   = 6;
	localparam int ADR_CHAN_BITS  = 3;
	localparam int ADR_INDEX_BITS = 6;

	// CTRL register bits
	localparam int CTRL_ARM        = 0;
	localparam int CTRL_MATCH_ALL  = 1;
	localparam int CTRL_EXT_TRIG   = 2;
	localparam int CTRL_STATUS_LSB = 8;

endpackage

// ==== hw/ila_top.sv ====
`timescale 1ns/1ps

module ila_top import ila_pkg::*; #(
	parameter int CHANNELS    = 2,
	parameter int PROBE_WIDTH = 16,
	parameter int DEPTH       = 64,
	localparam int ADDR_BITS  = $clog2(DEPTH),
	localparam int SAMPLE_W   = ila_sample_bits(CHANNELS, PROBE_WIDTH)
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe_in,
	input  logic                                 trig_in,	// External trigger
	output logic                                 trig_out,	// Trigger event, for cross triggering

	// Wishbone classic slave
	input  logic                                 wb_cyc,
	input  logic                                 wb_stb,
	input  logic                                 wb_we,
	input  logic [9:0]                           wb_adr,
	input  logic [31:0]                          wb_dat_i,
	output logic [31:0]                          wb_dat_o,
	output logic                                 wb_ack
);

	// Configuration from the register stage
	ila_compare_t                         mode [CHANNELS];
	logic [CHANNELS-1:0][PROBE_WIDTH-1:0] target;
	logic                                 match_all;
	logic                                 use_ext_trig;
	logic [ADDR_BITS-1:0]                 trig_offset;
	logic                                 arm_pulse;
	logic [ADDR_BITS-1:0]                 rd_addr;

	// Pipeline and readout
	logic [SAMPLE_W-1:0]                  beat;
	ila_status_t                          status;
	logic [CHANNELS-1:0][PROBE_WIDTH-1:0] rd_data;

	//////////////////////////////////////////////////////////////////////
	// Stage instances

	ila_trigger #(
		.CHANNELS    (CHANNELS),
		.PROBE_WIDTH (PROBE_WIDTH)
	) ila_trigger_inst (
		.clk, .arst_n, .probe_in, .mode, .target, .match_all, .use_ext_trig,
		.trig_in, .trig_out, .beat
	);

	ila_capture #(
		.CHANNELS    (CHANNELS),
		.PROBE_WIDTH (PROBE_WIDTH),
		.DEPTH       (DEPTH)
	) ila_capture_inst (
		.clk, .arst_n, .beat, .arm_pulse, .trig_offset, .rd_addr, .rd_data, .status
	);

	ila_wb_regs #(
		.CHANNELS    (CHANNELS),
		.PROBE_WIDTH (PROBE_WIDTH),
		.DEPTH       (DEPTH)
	) ila_wb_regs_inst (
		.clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
		.mode, .target, .match_all, .use_ext_trig, .trig_offset, .arm_pulse, .rd_addr,
		.status, .rd_data
	);

endmodule

// ==== hw/ila_trigger.sv ====
`timescale 1ns/1ps

module ila_trigger import ila_pkg::*; #(
	parameter int CHANNELS    = 2,
	parameter int PROBE_WIDTH = 16,
	localparam int SAMPLE_W   = ila_sample_bits(CHANNELS, PROBE_WIDTH)
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe_in,
	input  ila_compare_t                         mode [CHANNELS],
	input  logic [CHANNELS-1:0][PROBE_WIDTH-1:0] target,
	input  logic                                 match_all,	// AND of channels, else OR
	input  logic                                 use_ext_trig,	// Take trig_in instead
	input  logic                                 trig_in,
	output logic                                 trig_out,
	output logic [SAMPLE_W-1:0]                  beat
);

	typedef struct packed {
		logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe;
		logic                                 trig;
	} ila_sample_t;

	logic [CHANNELS-1:0]                  match_q;	// Phase 1 result
	logic                                 trig_in_q;	// External trigger, same stage as match_q
	logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe_d1;
	logic [CHANNELS-1:0][PROBE_WIDTH-1:0] probe_d2;
	ila_sample_t                          beat_s;

	//////////////////////////////////////////////////////////////////////
	// Phase 1: per-channel comparators

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			match_q   <= '0;
			trig_in_q <= 1'b0;
		end else begin
			trig_in_q <= trig_in;	// Keeps ext trigger on the comparator latency
			for (int i = 0; i < CHANNELS; i++) begin
				case (mode[i])
					COMPARE_ALWAYS:  match_q[i] <= 1'b1;
					COMPARE_NEVER:   match_q[i] <= 1'b0;
					COMPARE_EQUAL:   match_q[i] <= (probe_in[i] == target[i]);
					COMPARE_LEQUAL:  match_q[i] <= (probe_in[i] <= target[i]);
					COMPARE_GEQUAL:  match_q[i] <= (probe_in[i] >= target[i]);
					COMPARE_LESS:    match_q[i] <= (probe_in[i] < target[i]);
					COMPARE_GREATER: match_q[i] <= (probe_in[i] > target[i]);
					COMPARE_UNEQUAL: match_q[i] <= (probe_in[i] != target[i]);
					default:         match_q[i] <= 1'b0;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Phase 2: combine matches or pick external trigger

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			trig_out <= 1'b0;
		else if (use_ext_trig)
			trig_out <= trig_in_q;
		else if (match_all)
			trig_out <= &match_q;
		else
			trig_out <= |match_q;
	end

	// Two-stage probe delay, matches the compare + combine latency
	always_ff @(posedge clk) begin
		probe_d1 <= probe_in;
		probe_d2 <= probe_d1;
	end

	// Beat carries the probe value that produced its trig flag
	assign beat_s.probe = probe_d2;
	assign beat_s.trig  = trig_out;
	assign beat         = beat_s;

endmodule

// ==== hw/ila_wb_regs.sv ====
`timescale 1ns/1ps

module ila_wb_regs import ila_pkg::*; #(
	parameter int CHANNELS    = 2,	// Up to 8, limited by address decode
	parameter int PROBE_WIDTH = 16,	// Up to 32
	parameter int DEPTH       = 64,	// Up to 64
	localparam int ADDR_BITS  = $clog2(DEPTH),
	localparam int CH_BITS    = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
	input  logic                                 clk,
	input  logic                                 arst_n,

	// Wishbone classic slave
	input  logic                                 wb_cyc,
	input  logic                                 wb_stb,
	input  logic                                 wb_we,
	input  logic [9:0]                           wb_adr,
	input  logic [31:0]                          wb_dat_i,
	output logic [31:0]                          wb_dat_o,
	output logic                                 wb_ack,

	// Trigger configuration
	output ila_compare_t                         mode [CHANNELS],
	output logic [CHANNELS-1:0][PROBE_WIDTH-1:0] target,
	output logic                                 match_all,
	output logic                                 use_ext_trig,

	// Capture control and readout
	output logic [ADDR_BITS-1:0]                 trig_offset,
	output logic                                 arm_pulse,
	output logic [ADDR_BITS-1:0]                 rd_addr,
	input  ila_status_t                          status,
	input  logic [CHANNELS-1:0][PROBE_WIDTH-1:0] rd_data
);

	logic                      req;	// New access, not yet acked
	logic                      wr_en;
	logic                      smp_space;
	logic [ADR_INDEX_BITS-1:0] smp_index;
	logic [ADR_CHAN_BITS-1:0]  smp_chan;
	logic [CH_BITS-1:0]        ch_sel;
	logic [31:0]               reg_rdata;
	logic [31:0]               smp_rdata;

	assign req   = wb_cyc & wb_stb & ~wb_ack;
	assign wr_en = req & wb_we;

	//////////////////////////////////////////////////////////////////////
	// Bus handshake

	// Single-clock ack, one cycle after stb
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	//////////////////////////////////////////////////////////////////////
	// Configuration registers

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			match_all    <= 1'b0;
			use_ext_trig <= 1'b0;
			trig_offset  <= '0;
			arm_pulse    <= 1'b0;
			target       <= '0;
			for (int c = 0; c < CHANNELS; c++)
				mode[c] <= COMPARE_NEVER;	// Nothing triggers until configured
		end else begin
			arm_pulse <= wr_en && (wb_adr == REG_CTRL) && wb_dat_i[CTRL_ARM];	// Self clearing

			if (wr_en && wb_adr == REG_CTRL) begin
				match_all    <= wb_dat_i[CTRL_MATCH_ALL];
				use_ext_trig <= wb_dat_i[CTRL_EXT_TRIG];
			end
			if (wr_en && wb_adr == REG_OFFSET)
				trig_offset <= wb_dat_i[ADDR_BITS-1:0];

			for (int c = 0; c < CHANNELS; c++) begin
				if (wr_en && wb_adr == REG_MODE_BASE + 10'(c))
					mode[c] <= ila_compare_t'(wb_dat_i[2:0]);
				if (wr_en && wb_adr == REG_TARGET_BASE + 10'(c))
					target[c] <= wb_dat_i[PROBE_WIDTH-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback

	// Register space
	always_comb begin
		reg_rdata = '0;
		if (wb_adr == REG_CTRL) begin
			reg_rdata[CTRL_MATCH_ALL] = match_all;
			reg_rdata[CTRL_EXT_TRIG]  = use_ext_trig;
			reg_rdata[CTRL_STATUS_LSB +: $bits(ila_status_t)] = status;
		end else if (wb_adr == REG_OFFSET) begin
			reg_rdata[ADDR_BITS-1:0] = trig_offset;
		end
		for (int c = 0; c < CHANNELS; c++) begin
			if (wb_adr == REG_MODE_BASE + 10'(c))
				reg_rdata[2:0] = mode[c];
			if (wb_adr == REG_TARGET_BASE + 10'(c))
				reg_rdata[PROBE_WIDTH-1:0] = target[c];
		end
	end

	// Sample space: index goes out during stb, memory answers in the ack cycle
	assign smp_space = wb_adr[ADR_SAMPLE_BIT];
	assign smp_index = wb_adr[ADR_INDEX_BITS-1:0];
	assign smp_chan  = wb_adr[ADR_CHAN_LSB +: ADR_CHAN_BITS];
	assign ch_sel    = smp_chan[CH_BITS-1:0];
	assign rd_addr   = smp_index[ADDR_BITS-1:0];

	always_comb begin
		smp_rdata = '0;
		if (int'(smp_chan) < CHANNELS)	// Unused channels read as zero
			smp_rdata[PROBE_WIDTH-1:0] = rd_data[ch_sel];
	end

	assign wb_dat_o = smp_space ? smp_rdata : reg_rdata;

endmodule

// ==== ila_top.f ====
hw/ila_pkg.sv
hw/ila_trigger.sv
hw/ila_capture.sv
hw/ila_wb_regs.sv
hw/ila_top.sv
tb/ila_tb_assert.sv
tb/ila_tb.sv

// ==== tb/ila_tb.sv ====
`timescale 1ns/1ps

module ila_tb import ila_pkg::*; ();

	localparam int DEPTH       = 64;
	localparam int CLK_PERIOD  = 10;
	localparam int WATCHDOG_NS = (6 * DEPTH + 2000) * CLK_PERIOD;	// Six captures plus slack
	// Status field masks in the CTRL readback word
	localparam logic [31:0] ST_ARMED     = 32'd1 << CTRL_STATUS_LSB;
	localparam logic [31:0] ST_TRIGGERED = 32'd2 << CTRL_STATUS_LSB;
	localparam logic [31:0] ST_DONE      = 32'd4 << CTRL_STATUS_LSB;
	localparam logic [31:0] ST_PRE_FULL  = 32'd8 << CTRL_STATUS_LSB;
	localparam logic [31:0] ST_ALL       = 32'hf << CTRL_STATUS_LSB;

	logic             clk = 1'b0;
	logic             arst_n;
	logic [1:0][15:0] probe_in;
	logic             trig_in;
	logic             trig_out;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	logic [9:0]       wb_adr;
	logic [31:0]      wb_dat_i;
	logic [31:0]      wb_dat_o;
	logic             wb_ack;

	logic [15:0] cnt = '0;	// Free-running counter on channel 0
	logic [31:0] rnd = 32'hff0a_7f55;	// Xorshift state for channel 1
	logic [15:0] load_val = '0;	// Counter preset for the wrap case
	int          load_req = 0;
	int          load_ack = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;

	ila_top #(.CHANNELS(2), .PROBE_WIDTH(16), .DEPTH(DEPTH)) ila_top_inst (.*);

	bind ila_top ila_tb_assert ila_tb_assert_inst (
		.clk(clk), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
		.trig_out(trig_out), .arm_pulse(arm_pulse), .status(status)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Probes move on the falling edge and are stable at the sampling edge
	always @(negedge clk) begin
		if (load_req != load_ack) begin
			cnt      <= load_val;
			load_ack <= load_req;
		end else
			cnt <= cnt + 16'd1;
		rnd <= xorshift(rnd);
	end
	assign probe_in[0] = cnt;
	assign probe_in[1] = rnd[15:0];

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error %0t ns: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// One classic cycle with ack expected exactly one clock after stb
	task automatic bus_access(input logic we, input logic [9:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int lat = 0;
		@(negedge clk);
		check_value("ack idle before access", 32'(wb_ack), 32'd0);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_i = wdata;
		do begin
			@(negedge clk);
			lat++;
		end while (!wb_ack && lat < 8);
		check_value("ack latency", 32'(lat), 32'd1);
		rdata  = wb_dat_o;	// Valid while ack is high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [9:0] adr, input logic [31:0] data);
		logic [31:0] dummy;
		bus_access(1'b1, adr, data, dummy);
	endtask

	task automatic reg_read(input logic [9:0] adr, output logic [31:0] data);
		bus_access(1'b0, adr, 32'd0, data);
	endtask

	function automatic logic [9:0] sample_adr(input int chan, input int idx);
		return {1'b1, 3'(chan), 6'(idx)};	// Sample space, channel, index
	endfunction

	// Poll CTRL until a status bit shows up
	task automatic wait_status(input logic [31:0] mask, input string what,
			output logic [31:0] ctrl);
		int polls = 0;
		do begin
			reg_read(REG_CTRL, ctrl);
			polls++;
		end while ((ctrl & mask) == '0 && polls < 200);
		if ((ctrl & mask) == '0) begin
			$display("Status %s never came up after %0d polls", what, polls);
			errors++;
		end
	endtask

	// Channel setup followed by an arm with {ext, match_all}
	task automatic arm_capture(input ila_compare_t m0, input logic [15:0] t0,
			input ila_compare_t m1, input int offset, input logic [1:0] ctrl);
		reg_write(REG_MODE_BASE, 32'(m0));
		reg_write(REG_TARGET_BASE, 32'(t0));
		reg_write(REG_MODE_BASE + 10'd1, 32'(m1));
		reg_write(REG_OFFSET, 32'(offset));
		reg_write(REG_CTRL, {29'd0, ctrl, 1'b1});
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		tests++;
		$display("%s: %s", name, (errors == errors_at_start) ? "passed" : "failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [15:0] t;
		logic [15:0] ext_val;
		logic [15:0] ext_rnd;
		int          mark;
		arst_n   = 1'b0;
		trig_in  = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;

		mark = errors;	// Register readback
		reg_read(REG_MODE_BASE, rd);
		check_value("mode 0 after reset", rd, 32'(COMPARE_NEVER));
		reg_write(REG_OFFSET, 32'd37);
		reg_write(REG_MODE_BASE, 32'(COMPARE_GREATER));
		reg_write(REG_MODE_BASE + 10'd1, 32'(COMPARE_UNEQUAL));
		reg_write(REG_TARGET_BASE, 32'h1234);
		reg_write(REG_TARGET_BASE + 10'd1, 32'hbeef);
		reg_write(REG_CTRL, 32'h6);	// match_all, ext trigger, no arm
		reg_read(REG_OFFSET, rd);
		check_value("offset", rd, 32'd37);
		reg_read(REG_MODE_BASE, rd);
		check_value("mode 0", rd, 32'(COMPARE_GREATER));
		reg_read(REG_MODE_BASE + 10'd1, rd);
		check_value("mode 1", rd, 32'(COMPARE_UNEQUAL));
		reg_read(REG_TARGET_BASE, rd);
		check_value("target 0", rd, 32'h1234);
		reg_read(REG_TARGET_BASE + 10'd1, rd);
		check_value("target 1", rd, 32'hbeef);
		reg_read(REG_CTRL, rd);
		check_value("ctrl", rd, 32'h6);	// Status all clear
		report_test("test 1 register readback", mark);

		mark = errors;	// Equal trigger with full readout in time order
		t = cnt + 16'd60;
		arm_capture(COMPARE_EQUAL, t, COMPARE_NEVER, 10, 2'b00);
		wait_status(ST_DONE, "done", rd);
		for (int i = 0; i < DEPTH; i++) begin
			reg_read(sample_adr(0, i), rd);
			check_value("equal trigger sample", rd, 32'(t - 16'd10 + 16'(i)));
		end
		report_test("test 2 equal trigger", mark);

		mark = errors;	// Greater and then less-or-equal across the counter wrap
		t = cnt + 16'd60;
		arm_capture(COMPARE_GREATER, t, COMPARE_NEVER, 16, 2'b00);
		wait_status(ST_DONE, "done", rd);
		reg_read(sample_adr(0, 16), rd);
		check_value("greater trigger sample", rd, 32'(t + 16'd1));
		reg_read(sample_adr(0, 15), rd);
		check_value("greater sample before trigger", rd, 32'(t));
		load_val = 16'hffc0;
		load_req++;
		arm_capture(COMPARE_LEQUAL, 16'd20, COMPARE_NEVER, 8, 2'b00);
		wait_status(ST_DONE, "done", rd);
		reg_read(sample_adr(0, 8), rd);
		check_value("less-or-equal trigger sample", rd, 32'h0);
		reg_read(sample_adr(0, 7), rd);
		check_value("less-or-equal sample before trigger", rd, 32'hffff);
		report_test("test 3 ordered modes", mark);

		mark = errors;	// AND with a never channel blocks and OR lets channel 0 through
		t = cnt + 16'd40;
		arm_capture(COMPARE_EQUAL, t, COMPARE_NEVER, 4, 2'b01);
		do @(posedge clk); while (cnt != t + 16'd8);
		reg_read(REG_CTRL, rd);
		check_value("status with match_all", rd & ST_ALL, ST_ARMED | ST_PRE_FULL);
		t = cnt + 16'd60;
		arm_capture(COMPARE_EQUAL, t, COMPARE_NEVER, 4, 2'b00);
		wait_status(ST_DONE, "done", rd);
		reg_read(sample_adr(0, 4), rd);
		check_value("match_any trigger sample", rd, 32'(t));
		report_test("test 4 match combine", mark);

		mark = errors;	// External trigger with channel 0 always matching
		arm_capture(COMPARE_ALWAYS, 16'd0, COMPARE_NEVER, 12, 2'b10);
		wait_status(ST_PRE_FULL, "pre_full", rd);
		check_value("triggered before pulse", rd & ST_TRIGGERED, 32'd0);
		@(negedge clk);
		trig_in = 1'b1;
		@(posedge clk);
		ext_val = probe_in[0];	// Values sampled together with the pulse
		ext_rnd = probe_in[1];
		@(negedge clk);
		trig_in = 1'b0;
		check_value("trig_out one clock after pulse", 32'(trig_out), 32'd0);
		@(negedge clk);
		check_value("trig_out two clocks after pulse", 32'(trig_out), 32'd1);
		wait_status(ST_DONE, "done", rd);
		reg_read(sample_adr(0, 12), rd);
		check_value("external trigger sample", rd, 32'(ext_val));
		reg_read(sample_adr(1, 12), rd);
		check_value("external trigger sample channel 1", rd, 32'(ext_rnd));
		report_test("test 5 external trigger", mark);

		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, ila_top_inst.ila_tb_assert_inst.fail_cnt);
		if (errors == 0 && ila_top_inst.ila_tb_assert_inst.fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== tb/ila_tb_assert.sv ====
`timescale 1ns/1ps

module ila_tb_assert import ila_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        wb_cyc,
	input logic        wb_stb,
	input logic        wb_ack,
	input logic        trig_out,
	input logic        arm_pulse,
	input ila_status_t status
);

	int fail_cnt = 0;	// Failed assertion count

	//////////////////////////////////////////////////////////////////////
	// Wishbone handshake

	ack_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else begin $error("ack rose without cyc and stb"); fail_cnt++; end

	ack_one_clock: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack)	// Single-clock ack
		else begin $error("ack held longer than one clock"); fail_cnt++; end

	//////////////////////////////////////////////////////////////////////
	// Capture rules

	trig_after_pre_full: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(status.triggered) |-> $past(status.pre_full))
		else begin $error("triggered rose before pre-trigger history was full"); fail_cnt++; end

	done_until_arm: assert property (@(posedge clk) disable iff (!arst_n)
		status.done && !arm_pulse |=> status.done)	// Only a new arm clears it
		else begin $error("done dropped without a new arm"); fail_cnt++; end

	// Everything quiet right out of reset
	idle_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> !trig_out && !wb_ack && !status.armed && !status.done)
		else begin $error("outputs active after reset"); fail_cnt++; end

endmodule
